//--- vlog.f
common/drawPkg.sv
drawControl/drawControl.sv
verilog/tileScanner.sv
verilog/pixelPlacer.sv
verilog/drawEngine.sv
dv/tileRom.sv
dv/drawEngineTb.sv

//--- Makefile
# Verilator build for the tile drawing engine

VERILATOR  ?= verilator
TOP        ?= drawEngineTb
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
FAIL_TEXT  ?= TESTS FAILED
PASS_TEXT  ?= TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, the simulator status alone is not trusted
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/drawEngineTb.sv
// testbench for the tile drawing engine, random placements checked against a pixel stream model
`timescale 1ns/1ps

module drawEngineTb;
   import drawPkg::*;

   typedef struct packed {
      logic [screenXBits-1:0] x;
      logic [screenYBits-1:0] y;
      logic [colourBits-1:0]  colour;
   } pixelEntry_t;

   localparam int doneTimeout   = 25000;  // cycles, a full scatter is 19200
   localparam int plotTimeout   = 10;
   localparam int scatterPixels = 4 * tilePixels;

   logic                   iClock;
   logic                   arstN;
   logic                   draw;
   logic [1:0]             imageSelect;
   logic [1:0]             location;
   logic [colourBits-1:0]  romColour;
   logic [1:0]             romTile;
   logic [romAddrBits-1:0] romAddr;
   logic                   oPlot;
   logic [screenXBits-1:0] oX;
   logic [screenYBits-1:0] oY;
   logic [colourBits-1:0]  oColour;
   logic                   oDone;

   pixelEntry_t expectQ[$];  // pixels still to come, in plot order
   int          plotRun;     // length of the oPlot run in progress
   int          lastRun;     // length of the last finished oPlot run
   string       testName;

   initial begin
      iClock = 1'b0;
      forever #20 iClock = ~iClock;
   end

   drawEngine drawEngine_inst (
      .iClock      (iClock),
      .arstN       (arstN),
      .draw        (draw),
      .imageSelect (imageSelect),
      .location    (location),
      .romColour   (romColour),
      .romTile     (romTile),
      .romAddr     (romAddr),
      .oPlot       (oPlot),
      .oX          (oX),
      .oY          (oY),
      .oColour     (oColour),
      .oDone       (oDone)
   );

   tileRom tileRom_inst (
      .iClock (iClock),
      .tile   (romTile),
      .addr   (romAddr),
      .colour (romColour)
   );

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // screen origin of a tile, scatter spots by tile or right half slots
   function automatic logic [screenXBits-1:0] pivotXOf(input logic placeMode,
                                                       input logic [1:0] tile,
                                                       input logic [1:0] slot);
      if (placeMode) begin
         return slot[0] ? 10'd240 : 10'd160;
      end else begin
         return tile[0] ? 10'd81 : 10'd0;
      end
   endfunction

   function automatic logic [screenYBits-1:0] pivotYOf(input logic placeMode,
                                                       input logic [1:0] tile,
                                                       input logic [1:0] slot);
      if (placeMode) begin
         return slot[1] ? 9'd60 : 9'd0;
      end else begin
         return tile[1] ? 9'd61 : 9'd0;
      end
   endfunction

   function automatic logic [colourBits-1:0] romColourFor(input logic [1:0] tile,
                                                          input logic [romAddrBits-1:0] addr);
      logic [7:0] tag;
      tag = 8'(tile) + 8'd1;
      return {tag, 3'b000, addr};
   endfunction

   task automatic pushTile(input logic placeMode, input logic [1:0] tile, input logic [1:0] slot);
      pixelEntry_t            entry;
      logic [screenXBits-1:0] baseX;
      logic [screenYBits-1:0] baseY;
      baseX = pivotXOf(placeMode, tile, slot);
      baseY = pivotYOf(placeMode, tile, slot);
      for (int y = 0; y < tileHeight; y++) begin
         for (int x = 0; x < tileWidth; x++) begin  // raster order, x fastest
            entry.x      = baseX + screenXBits'(x);
            entry.y      = baseY + screenYBits'(y);
            entry.colour = romColourFor(tile, romAddrBits'(y * tileWidth + x));
            expectQ.push_back(entry);
         end
      end
   endtask

   task automatic pushScatter();
      for (int t = 0; t < 4; t++) begin
         pushTile(1'b0, 2'(t), 2'd0);
      end
   endtask

   task automatic checkOutputs();
      pixelEntry_t expected;
      if (!arstN) begin
         plotRun = 0;
         assert (!oPlot && !oDone)
            else failRun("oPlot or oDone is high while reset is asserted");
      end else if (oPlot) begin
         plotRun++;
         assert (expectQ.size() != 0)
            else failRun($sformatf("%s: a pixel was plotted when none was expected", testName));
         if (expectQ.size() != 0) begin
            expected = expectQ.pop_front();
            assert (oX == expected.x)
               else failRun($sformatf("Fail %s oX: expected %0d actual %0d",
                                      testName, expected.x, oX));
            assert (oY == expected.y)
               else failRun($sformatf("Fail %s oY: expected %0d actual %0d",
                                      testName, expected.y, oY));
            assert (oColour == expected.colour)
               else failRun($sformatf("Fail %s oColour: expected %06h actual %06h",
                                      testName, expected.colour, oColour));
         end
      end else if (plotRun != 0) begin
         lastRun = plotRun;  // run just ended
         plotRun = 0;
      end
   endtask

   // outputs checked mid cycle, inputs driven just after the rising edge
   task automatic nextCycle();
      @(negedge iClock);
      checkOutputs();
      @(posedge iClock);
      #2;
   endtask

   task automatic waitForDone(input string what, input logic noise);
      int cycles;
      cycles = 0;
      while (!oDone) begin
         if (noise) begin
            // engine busy, so these draws must be ignored
            draw        = ($urandom_range(0, 3) == 0);
            imageSelect = 2'($urandom_range(0, 3));
            location    = 2'($urandom_range(0, 3));
         end
         nextCycle();
         cycles++;
         if (cycles > doneTimeout) begin
            failRun($sformatf("timeout while waiting for oDone in %s", what));
         end
      end
      draw = 1'b0;
   endtask

   task automatic waitForPlot(input string what);
      int cycles;
      cycles = 0;
      while (!oPlot) begin
         nextCycle();
         cycles++;
         if (cycles > plotTimeout) begin
            failRun($sformatf("timeout while waiting for oPlot in %s", what));
         end
      end
   endtask

   task automatic drainCheck(input string what, input int count);
      repeat (3) nextCycle();  // last pixel leaves within two cycles of done
      assert (expectQ.size() == 0)
         else failRun($sformatf("%s: %0d expected pixels never arrived", what, expectQ.size()));
      // pixels of one job come without gaps
      assert (lastRun == count)
         else failRun($sformatf("Fail %s plot run length: expected %0d actual %0d",
                                what, count, lastRun));
      assert (oDone)
         else failRun($sformatf("%s: oDone dropped without a draw", what));
   endtask

   task automatic issueDraw(input string name);
      logic [1:0] tile;
      logic [1:0] slot;
      testName = name;
      assert (oDone)
         else failRun($sformatf("%s: engine was not idle before the draw", name));
      tile        = 2'($urandom_range(0, 3));
      slot        = 2'($urandom_range(0, 3));
      imageSelect = tile;
      location    = slot;
      draw        = 1'b1;
      pushTile(1'b1, tile, slot);
      nextCycle();
      draw = 1'b0;
      assert (!oDone)
         else failRun($sformatf("%s: oDone stayed high after a draw in idle", name));
   endtask

   task automatic placeTile(input string name, input logic noise);
      issueDraw(name);
      waitForDone(name, noise);
      drainCheck(name, tilePixels);
   endtask

   initial begin
      int holdCycles;
      void'($urandom(80272));
      arstN       = 1'b0;
      draw        = 1'b0;
      imageSelect = 2'd0;
      location    = 2'd0;
      plotRun     = 0;
      lastRun     = 0;
      testName    = "scatter";

      // scatter after power up
      repeat (2) nextCycle();
      pushScatter();
      arstN = 1'b1;
      waitForDone("scatter", 1'b0);
      drainCheck("scatter", scatterPixels);

      repeat (12) placeTile("placement", 1'b0);
      // busy draws and moving selections while a tile is drawn
      repeat (6) placeTile("busyDraw", 1'b1);

      // reset in the middle of a placement
      issueDraw("resetMidPlacement");
      waitForPlot("resetMidPlacement");
      holdCycles = $urandom_range(100, 4000);
      repeat (holdCycles) nextCycle();
      arstN = 1'b0;
      expectQ.delete();
      repeat (2) nextCycle();
      testName = "rescatter";
      pushScatter();
      arstN = 1'b1;
      waitForDone("rescatter", 1'b0);
      drainCheck("rescatter", scatterPixels);

      testName = "endOfTest";
      if (expectQ.size() == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         failRun("expected pixels left over at the end of the run");
      end
   end

endmodule

//--- dv/tileRom.sv
// behavioural tile rom, one cycle read latency, colour built from tile index and address
`timescale 1ns/1ps

module tileRom (
   input  logic                            iClock,
   input  logic [1:0]                      tile,
   input  logic [drawPkg::romAddrBits-1:0] addr,
   output logic [drawPkg::colourBits-1:0]  colour
);

   logic [7:0] tileTag;  // tile plus one, never zero

   assign tileTag = {6'd0, tile} + 8'd1;

   // red byte marks the tile, low bits repeat the address
   always_ff @(posedge iClock) begin
      colour <= {tileTag, 3'b000, addr};
   end

endmodule

//--- verilog/drawEngine.sv
// tile drawing engine top, scatters four tiles then places tiles into slots on request
`timescale 1ns/1ps

module drawEngine (
   input  logic                            iClock,
   input  logic                            arstN,

   // placement request
   input  logic                            draw,
   input  logic [1:0]                      imageSelect,
   input  logic [1:0]                      location,

   // tile rom, one cycle read latency
   input  logic [drawPkg::colourBits-1:0]  romColour,
   output logic [1:0]                      romTile,
   output logic [drawPkg::romAddrBits-1:0] romAddr,

   // pixel plotter
   output logic                            oPlot,
   output logic [drawPkg::screenXBits-1:0] oX,
   output logic [drawPkg::screenYBits-1:0] oY,
   output logic [drawPkg::colourBits-1:0]  oColour,
   output logic                            oDone
);
   import drawPkg::*;

   drawCmd_t cmd;  // current tile job
   scanPos_t pos;  // scan position, also the rom address

   drawControl drawControl_inst (
      .iClock      (iClock),
      .arstN       (arstN),
      .draw        (draw),
      .imageSelect (imageSelect),
      .location    (location),
      .scanLast    (pos.last),
      .cmd         (cmd),
      .oDone       (oDone)
   );

   tileScanner tileScanner_inst (
      .iClock (iClock),
      .arstN  (arstN),
      .cmd    (cmd),
      .pos    (pos)
   );

   // rom reads the tile that is being scanned
   assign romTile = cmd.tile;
   assign romAddr = pos.addr;

   pixelPlacer pixelPlacer_inst (
      .iClock    (iClock),
      .arstN     (arstN),
      .cmd       (cmd),
      .pos       (pos),
      .romColour (romColour),
      .oPlot     (oPlot),
      .oX        (oX),
      .oY        (oY),
      .oColour   (oColour)
   );

endmodule

//--- verilog/pixelPlacer.sv
// two stage pixel pipeline, lines scan positions up with rom data and adds the pivot
`timescale 1ns/1ps

module pixelPlacer (
   input  logic                            iClock,
   input  logic                            arstN,
   input  drawPkg::drawCmd_t               cmd,
   input  drawPkg::scanPos_t               pos,
   input  logic [drawPkg::colourBits-1:0]  romColour,
   output logic                            oPlot,
   output logic [drawPkg::screenXBits-1:0] oX,
   output logic [drawPkg::screenYBits-1:0] oY,
   output logic [drawPkg::colourBits-1:0]  oColour
);
   import drawPkg::*;

   drawCmd_t cmdQ;  // stage one, rom read in flight
   scanPos_t posQ;

   logic [screenXBits-1:0] pivotX;
   logic [screenYBits-1:0] pivotY;
   logic [screenXBits-1:0] tileX;
   logic [screenYBits-1:0] tileY;

   // stage one
   always_ff @(posedge iClock or negedge arstN) begin
      if (!arstN) begin
         cmdQ <= '0;
      end else begin
         cmdQ <= cmd;
      end
   end

   always_ff @(posedge iClock) begin
      posQ <= pos;
   end

   // pivot from the scatter table or the slot table
   always_comb begin
      if (cmdQ.placeMode) begin
         pivotX = slotPivotX[cmdQ.slot];
         pivotY = slotPivotY[cmdQ.slot];
      end else begin
         pivotX = scatterPivotX[cmdQ.tile];
         pivotY = scatterPivotY[cmdQ.tile];
      end
   end

   assign tileX = {{(screenXBits - tileXBits){1'b0}}, posQ.x};
   assign tileY = {{(screenYBits - tileYBits){1'b0}}, posQ.y};

   // stage two, plotter outputs
   always_ff @(posedge iClock or negedge arstN) begin
      if (!arstN) begin
         oPlot <= 1'b0;
      end else begin
         oPlot <= cmdQ.active;
      end
   end

   always_ff @(posedge iClock) begin
      oX      <= pivotX + tileX;
      oY      <= pivotY + tileY;
      oColour <= romColour;  // arrives one cycle after the address
   end

   // every plotted pixel lands on the screen
   assert property (@(posedge iClock) disable iff (!arstN)
      oPlot |-> (oX < screenXBits'(screenWidth)) && (oY < screenYBits'(screenHeight)));

endmodule

//--- verilog/tileScanner.sv
// raster scanner over one tile, gives tile x/y, rom address and last pixel flag
`timescale 1ns/1ps

module tileScanner (
   input  logic              iClock,
   input  logic              arstN,
   input  drawPkg::drawCmd_t cmd,
   output drawPkg::scanPos_t pos
);
   import drawPkg::*;

   logic [tileXBits-1:0]   xCnt;
   logic [tileYBits-1:0]   yCnt;
   logic [romAddrBits-1:0] addrCnt;  // running y*80+x
   logic                   atLastX;
   logic                   atLastPixel;

   assign atLastX     = (xCnt == tileXBits'(tileWidth - 1));
   assign atLastPixel = atLastX && (yCnt == tileYBits'(tileHeight - 1));

   always_ff @(posedge iClock or negedge arstN) begin
      if (!arstN) begin
         xCnt    <= '0;
         yCnt    <= '0;
         addrCnt <= '0;
      end else if (cmd.active) begin
         if (atLastPixel) begin
            // wrap, next tile may follow directly
            xCnt    <= '0;
            yCnt    <= '0;
            addrCnt <= '0;
         end else if (atLastX) begin
            xCnt    <= '0;
            yCnt    <= yCnt + 1'b1;
            addrCnt <= addrCnt + 1'b1;
         end else begin
            xCnt    <= xCnt + 1'b1;
            addrCnt <= addrCnt + 1'b1;
         end
      end else begin
         xCnt    <= '0;  // parked at origin when idle
         yCnt    <= '0;
         addrCnt <= '0;
      end
   end

   always_comb begin
      pos.x    = xCnt;
      pos.y    = yCnt;
      pos.addr = addrCnt;
      pos.last = atLastPixel;
   end

   assert property (@(posedge iClock) disable iff (!arstN)
      addrCnt < romAddrBits'(tilePixels));

endmodule

//--- drawControl/drawControl.sv
// drawing controller FSM, sequences the scatter tiles then serves placement requests
`timescale 1ns/1ps

module drawControl (
   input  logic              iClock,
   input  logic              arstN,
   input  logic              draw,
   input  logic [1:0]        imageSelect,
   input  logic [1:0]        location,
   input  logic              scanLast,
   output drawPkg::drawCmd_t cmd,
   output logic              oDone
);
   import drawPkg::*;

   drawState_t state;
   drawState_t nextState;

   logic [1:0] scatterTile;  // tile being scattered
   logic [1:0] selTile;      // latched at draw
   logic [1:0] selSlot;

   // next state
   always_comb begin
      nextState = state;
      unique case (state)
         stReset: begin
            nextState = stScatter;
         end
         stScatter: begin
            // tile 3 done ends the scatter phase
            if (scanLast && (scatterTile == 2'd3)) begin
               nextState = stIdle;
            end
         end
         stIdle: begin
            if (draw) begin
               nextState = stPlace;
            end
         end
         stPlace: begin
            if (scanLast) begin
               nextState = stIdle;
            end
         end
      endcase
   end

   always_ff @(posedge iClock or negedge arstN) begin
      if (!arstN) begin
         state <= stReset;
      end else begin
         state <= nextState;
      end
   end

   // scatter order is simply tile 0 to 3, wraps back to 0 after tile 3
   always_ff @(posedge iClock or negedge arstN) begin
      if (!arstN) begin
         scatterTile <= '0;
      end else if ((state == stScatter) && scanLast) begin
         scatterTile <= scatterTile + 2'd1;
      end
   end

   // selections only sampled on an accepted draw
   always_ff @(posedge iClock) begin
      if ((state == stIdle) && draw) begin
         selTile <= imageSelect;
         selSlot <= location;
      end
   end

   always_comb begin
      cmd.active    = (state == stScatter) || (state == stPlace);
      cmd.placeMode = (state == stPlace);
      if (state == stPlace) begin
         cmd.tile = selTile;
         cmd.slot = selSlot;
      end else begin
         cmd.tile = scatterTile;
         cmd.slot = 2'd0;  // slot unused while scattering
      end
   end

   assign oDone = (state == stIdle);

   // scanner counters must be parked whenever nothing is being drawn
   assert property (@(posedge iClock) disable iff (!arstN)
      scanLast |-> cmd.active);

   // accepted draw starts a placement of the selected tile and slot
   assert property (@(posedge iClock) disable iff (!arstN)
      (state == stIdle) && draw |=> (state == stPlace)
         && (cmd.tile == $past(imageSelect)) && (cmd.slot == $past(location)));

endmodule

//--- common/drawPkg.sv
// tile drawing engine package with screen geometry, pivot tables and shared types
package drawPkg;

   // one tile is one rom image
   localparam int tileWidth  = 80;
   localparam int tileHeight = 60;
   localparam int tilePixels = tileWidth * tileHeight;  // 4800

   // plotter side
   localparam int screenWidth  = 320;
   localparam int screenHeight = 240;
   localparam int screenXBits  = 10;
   localparam int screenYBits  = 9;
   localparam int colourBits   = 24;  // rgb

   // counters inside a tile
   localparam int tileXBits   = 7;
   localparam int tileYBits   = 6;
   localparam int romAddrBits = 13;

   // pivot tables, entry 0 sits in the low bits
   // scatter positions on the left half, indexed by tile
   localparam logic [3:0][screenXBits-1:0] scatterPivotX = {
      10'd81, 10'd0, 10'd81, 10'd0
   };
   localparam logic [3:0][screenYBits-1:0] scatterPivotY = {
      9'd61, 9'd61, 9'd0, 9'd0
   };

   // placement slots on the right half, indexed by slot
   localparam logic [3:0][screenXBits-1:0] slotPivotX = {
      10'd240, 10'd160, 10'd240, 10'd160
   };
   localparam logic [3:0][screenYBits-1:0] slotPivotY = {
      9'd60, 9'd60, 9'd0, 9'd0
   };

   // controller states
   typedef enum logic [1:0] {
      stReset,
      stScatter,
      stIdle,
      stPlace
   } drawState_t;

   // one scan position inside a tile
   typedef struct packed {
      logic [tileXBits-1:0]   x;
      logic [tileYBits-1:0]   y;
      logic [romAddrBits-1:0] addr;
      logic                   last;  // final pixel of the tile
   } scanPos_t;

   // what is being drawn right now
   typedef struct packed {
      logic       active;
      logic       placeMode;  // 0 scatter, 1 placement
      logic [1:0] tile;
      logic [1:0] slot;
   } drawCmd_t;

endpackage
